// ==== logic/lpf_defines.svh ====
// --------------------------------------------------
// LPF voice filter constants
// Datapath widths, fixed-point shift, MIDI mapping
// and parameter defaults
// --------------------------------------------------
`ifndef LPF_DEFINES_SVH
`define LPF_DEFINES_SVH

// Datapath widths
`define LPF_SAMPLE_W   18
`define LPF_PARAM_W    18
`define LPF_COEF_W     20
`define LPF_ACC_W      48

// Fixed-point shift, 1.0 is 65536
`define LPF_FRAC       16

// Channel and Control Change numbers the filter reacts to
`define LPF_MIDI_CH    4'd0
`define LPF_CC_OMEGA0  7'd21
`define LPF_CC_INV_2Q  7'd22

// Parameters after reset
`define LPF_OMEGA0_RST 18'h01999
`define LPF_INV_2Q_RST 18'h08000

`endif

// ==== logic/midi_pkg.sv ====
// --------------------------------------------------
// MIDI event types
// Command kinds and field widths from the parser
// --------------------------------------------------
package midi_pkg;

    // Command kind, decoded from the status nibble
    typedef enum logic [2:0] {
        MIDI_NOTE_OFF    = 3'd0,
        MIDI_NOTE_ON     = 3'd1,
        MIDI_AFTERTOUCH  = 3'd2,
        MIDI_CC          = 3'd3,
        MIDI_PROG_CHANGE = 3'd4,
        MIDI_CH_PRESSURE = 3'd5,
        MIDI_PITCH_BEND  = 3'd6,
        MIDI_SYSTEM      = 3'd7
    } midi_cmd_t;

    // Channel number, or subcode for system messages
    typedef logic [3:0] midi_ch_t;

    // Data byte without the status bit
    typedef logic [6:0] midi_data_t;

endpackage

// ==== logic/dsp_pkg.sv ====
// --------------------------------------------------
// Filter datapath types
// Samples, parameters, coefficients, accumulator
// and the controller states
// --------------------------------------------------
`include "lpf_defines.svh"

package dsp_pkg;

    // Audio sample, Q1.16
    typedef logic signed [`LPF_SAMPLE_W-1:0] sample_t;

    // Filter parameter, Q2.16, never negative
    typedef logic [`LPF_PARAM_W-1:0] param_t;

    // Biquad coefficient, Q3.16
    typedef logic signed [`LPF_COEF_W-1:0] coef_t;

    // MAC accumulator
    typedef logic signed [`LPF_ACC_W-1:0] acc_t;

    // Controller FSM
    typedef enum logic [1:0] {
        ST_IDLE        = 2'd0,
        ST_CALC_SAMPLE = 2'd1,
        ST_CALC_COEFS  = 2'd2,
        ST_DONE        = 2'd3
    } lpf_state_t;

endpackage

// ==== logic/midi_cc_decoder.sv ====
// --------------------------------------------------
// MIDI Control Change decoder
// Maps two CC numbers on one channel onto the
// cutoff and damping parameters
// --------------------------------------------------
`timescale 1ns/1ps
`include "lpf_defines.svh"

module midi_cc_decoder (
    input  logic                 reset,
    input  logic                 clk,
    input  logic                 midi_rdy,
    input  midi_pkg::midi_cmd_t  midi_cmd,
    input  midi_pkg::midi_ch_t   midi_ch,
    input  midi_pkg::midi_data_t midi_data0,
    input  midi_pkg::midi_data_t midi_data1,
    input  logic                 clear_changed,
    output dsp_pkg::param_t      omega0,
    output dsp_pkg::param_t      inv_2q,
    output logic                 params_changed
);

    logic cc_event;
    logic hit_omega0;
    logic hit_inv_2q;

    // Control Change on our channel only
    assign cc_event = midi_rdy &&
                      (midi_cmd == midi_pkg::MIDI_CC) &&
                      (midi_ch == `LPF_MIDI_CH);

    // data0 holds the controller number
    assign hit_omega0 = cc_event && (midi_data0 == `LPF_CC_OMEGA0);
    assign hit_inv_2q = cc_event && (midi_data0 == `LPF_CC_INV_2Q);

    // Port reset is the clock, clk the async reset
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            omega0         <= `LPF_OMEGA0_RST;
            inv_2q         <= `LPF_INV_2Q_RST;
            // Forces a coefficient pass after the first sample
            params_changed <= 1'b1;
        end else begin
            // Cutoff: up to about 0.5 in Q2.16
            if (hit_omega0) begin
                omega0 <= {3'b000, midi_data1, 8'hff};
            end
            // Damping: up to about 1.0
            if (hit_inv_2q) begin
                inv_2q <= {2'b00, midi_data1, 9'h1ff};
            end
            // New CC beats a clear in the same cycle
            if (hit_omega0 || hit_inv_2q) begin
                params_changed <= 1'b1;
            end else if (clear_changed) begin
                params_changed <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/lpf_coefs_calc.sv ====
// --------------------------------------------------
// Biquad coefficient calculator
// Builds b0..a2 from omega0 and inv_2q with one
// shared multiplier, no division
// --------------------------------------------------
`timescale 1ns/1ps
`include "lpf_defines.svh"

module lpf_coefs_calc (
    input  logic            reset,
    input  logic            clk,
    input  logic            do_calc,
    input  dsp_pkg::param_t omega0,
    input  dsp_pkg::param_t inv_2q,
    output dsp_pkg::coef_t  b0,
    output dsp_pkg::coef_t  b1,
    output dsp_pkg::coef_t  b2,
    output dsp_pkg::coef_t  a1,
    output dsp_pkg::coef_t  a2,
    output logic            calc_done
);

    // Constants in Q3.16
    localparam dsp_pkg::coef_t COEF_ONE  = dsp_pkg::coef_t'(1 << `LPF_FRAC);
    localparam dsp_pkg::coef_t COEF_TWO  = dsp_pkg::coef_t'(2 << `LPF_FRAC);
    localparam dsp_pkg::coef_t COEF_HALF = dsp_pkg::coef_t'(1 << (`LPF_FRAC - 1));
    localparam int             ZEXT_W    = `LPF_COEF_W - `LPF_PARAM_W;
    localparam logic [2:0]     STEP_LAST = 3'd4;

    logic [2:0]                      step;
    dsp_pkg::param_t                 omega0_q;
    dsp_pkg::param_t                 inv_2q_q;
    dsp_pkg::coef_t                  omega0_op;
    dsp_pkg::coef_t                  inv_2q_op;
    dsp_pkg::coef_t                  mul_a;
    dsp_pkg::coef_t                  mul_b;
    logic signed [2*`LPF_COEF_W-1:0] prod;
    logic signed [2*`LPF_COEF_W-1:0] prod_shr;
    dsp_pkg::coef_t                  w2;
    dsp_pkg::coef_t                  wd;

    // Parameters are positive, zero-extend into signed operands
    assign omega0_op = {{ZEXT_W{1'b0}}, omega0_q};
    assign inv_2q_op = {{ZEXT_W{1'b0}}, inv_2q_q};

    // ------------------------------------------------
    // Shared multiplier, operands picked by step
    // ------------------------------------------------
    always_comb begin
        mul_a = '0;
        mul_b = '0;
        case (step)
            3'd1: begin
                mul_a = omega0_op;
                mul_b = omega0_op;
            end
            3'd2: begin
                mul_a = omega0_op;
                mul_b = inv_2q_op;
            end
            // w2 / 2 for b1
            3'd3: begin
                mul_a = w2;
                mul_b = COEF_HALF;
            end
            default: begin
                mul_a = '0;
                mul_b = '0;
            end
        endcase
    end

    assign prod     = mul_a * mul_b;
    // Truncating shift back to Q.16
    assign prod_shr = prod >>> `LPF_FRAC;

    // Sequencer, 1..4 while busy
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            step      <= '0;
            calc_done <= 1'b0;
        end else begin
            calc_done <= (step == STEP_LAST);
            if (do_calc) begin
                step <= 3'd1;
            end else if (step == STEP_LAST) begin
                step <= '0;
            end else if (step != 3'd0) begin
                step <= step + 3'd1;
            end
        end
    end

    // Operands and results
    always_ff @(posedge reset) begin
        // Snapshot so later CCs cannot disturb this pass
        if (do_calc) begin
            omega0_q <= omega0;
            inv_2q_q <= inv_2q;
        end
        if (step == 3'd1) begin
            w2 <= prod_shr[`LPF_COEF_W-1:0];
        end
        // Damping term counted twice
        if (step == 3'd2) begin
            wd <= {prod_shr[`LPF_COEF_W-2:0], 1'b0};
        end
        if (step == 3'd3) begin
            b0 <= w2 >>> 2;
            b1 <= prod_shr[`LPF_COEF_W-1:0];
            b2 <= w2 >>> 2;
        end
        // Feedback terms, a2 is subtracted by the biquad
        if (step == STEP_LAST) begin
            a1 <= COEF_TWO - w2 - wd;
            a2 <= COEF_ONE - wd;
        end
    end

endmodule

// ==== logic/lpf_iir_biquad.sv ====
// --------------------------------------------------
// Direct Form I biquad
// Five sequential MACs on one multiplier, then
// shift, saturate and flag overflow
// --------------------------------------------------
`timescale 1ns/1ps
`include "lpf_defines.svh"

module lpf_iir_biquad (
    input  logic             reset,
    input  logic             clk,
    input  logic             start,
    input  dsp_pkg::sample_t sample_in,
    input  dsp_pkg::coef_t   b0,
    input  dsp_pkg::coef_t   b1,
    input  dsp_pkg::coef_t   b2,
    input  dsp_pkg::coef_t   a1,
    input  dsp_pkg::coef_t   a2,
    output logic             done,
    output dsp_pkg::sample_t sample_out,
    output logic             overflow
);

    localparam int               PROD_W      = `LPF_COEF_W + `LPF_SAMPLE_W;
    localparam int               UPPER_W     = `LPF_ACC_W - `LPF_SAMPLE_W + 1;
    localparam dsp_pkg::sample_t SAMPLE_MAX  = {1'b0, {(`LPF_SAMPLE_W-1){1'b1}}};
    localparam dsp_pkg::sample_t SAMPLE_MIN  = {1'b1, {(`LPF_SAMPLE_W-1){1'b0}}};
    localparam logic [2:0]       STEP_RESULT = 3'd5;

    logic [2:0]               step;
    logic                     take;
    logic                     mac_en;
    dsp_pkg::sample_t         x0;
    dsp_pkg::sample_t         x1;
    dsp_pkg::sample_t         x2;
    dsp_pkg::sample_t         y1;
    dsp_pkg::sample_t         y2;
    dsp_pkg::coef_t           mac_coef;
    dsp_pkg::sample_t         mac_data;
    logic signed [PROD_W-1:0] prod;
    dsp_pkg::acc_t            acc;
    dsp_pkg::acc_t            acc_next;
    dsp_pkg::acc_t            acc_shr;
    logic [UPPER_W-1:0]       upper;
    logic                     range_err;
    dsp_pkg::sample_t         sat_val;

    // Step 0 is idle and also the first MAC on start
    assign take   = start && (step == 3'd0);
    assign mac_en = take || ((step != 3'd0) && (step < STEP_RESULT));

    // ------------------------------------------------
    // MAC operand select
    // ------------------------------------------------
    always_comb begin
        case (step)
            // Current sample straight from the port
            3'd0: begin
                mac_coef = b0;
                mac_data = sample_in;
            end
            3'd1: begin
                mac_coef = b1;
                mac_data = x1;
            end
            3'd2: begin
                mac_coef = b2;
                mac_data = x2;
            end
            3'd3: begin
                mac_coef = a1;
                mac_data = y1;
            end
            3'd4: begin
                mac_coef = a2;
                mac_data = y2;
            end
            default: begin
                mac_coef = '0;
                mac_data = '0;
            end
        endcase
    end

    assign prod = mac_coef * mac_data;

    // a2 term subtracts
    always_comb begin
        case (step)
            3'd0:    acc_next = dsp_pkg::acc_t'(prod);
            3'd4:    acc_next = acc - dsp_pkg::acc_t'(prod);
            default: acc_next = acc + dsp_pkg::acc_t'(prod);
        endcase
    end

    // ------------------------------------------------
    // Scale back and clip to 18 bits
    // ------------------------------------------------
    assign acc_shr   = acc >>> `LPF_FRAC;
    assign upper     = acc_shr[`LPF_ACC_W-1:`LPF_SAMPLE_W-1];
    // In range only if sign bit and all above agree
    assign range_err = !((&upper) || !(|upper));
    assign sat_val   = range_err ? (acc_shr[`LPF_ACC_W-1] ? SAMPLE_MIN : SAMPLE_MAX)
                                 : acc_shr[`LPF_SAMPLE_W-1:0];

    // Sequencer and filter history
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            step     <= '0;
            done     <= 1'b0;
            overflow <= 1'b0;
            x1       <= '0;
            x2       <= '0;
            y1       <= '0;
            y2       <= '0;
        end else begin
            done     <= 1'b0;
            overflow <= 1'b0;
            if (take) begin
                step <= 3'd1;
            end else if (step == STEP_RESULT) begin
                step     <= '0;
                done     <= 1'b1;
                overflow <= range_err;
                x1       <= x0;
                x2       <= x1;
                // Clipped value is what feeds back
                y1       <= sat_val;
                y2       <= y1;
            end else if (step != 3'd0) begin
                step <= step + 3'd1;
            end
        end
    end

    // Datapath registers
    always_ff @(posedge reset) begin
        if (take) begin
            x0 <= sample_in;
        end
        if (mac_en) begin
            acc <= acc_next;
        end
        // Held until the next result
        if (step == STEP_RESULT) begin
            sample_out <= sat_val;
        end
    end

endmodule

// ==== logic/lpf_voice_filter.sv ====
// --------------------------------------------------
// MIDI-controlled resonant low-pass for one voice
// Controller FSM, coefficient bank and the chain
// decoder -> coefficient calc -> biquad
// --------------------------------------------------
`timescale 1ns/1ps

module lpf_voice_filter (
    input  logic                 reset,
    input  logic                 clk,
    input  logic                 midi_rdy,
    input  midi_pkg::midi_cmd_t  midi_cmd,
    input  midi_pkg::midi_ch_t   midi_ch,
    input  midi_pkg::midi_data_t midi_data0,
    input  midi_pkg::midi_data_t midi_data1,
    input  logic                 sample_in_rdy,
    input  dsp_pkg::sample_t     sample_in,
    output logic                 sample_out_rdy,
    output dsp_pkg::sample_t     sample_out,
    output logic                 err_overflow
);

    dsp_pkg::lpf_state_t state;
    dsp_pkg::lpf_state_t next_state;
    dsp_pkg::param_t     omega0;
    dsp_pkg::param_t     inv_2q;
    logic                params_changed;
    logic                do_calc;
    logic                calc_done;
    logic                iir_start;
    dsp_pkg::coef_t      calc_b0;
    dsp_pkg::coef_t      calc_b1;
    dsp_pkg::coef_t      calc_b2;
    dsp_pkg::coef_t      calc_a1;
    dsp_pkg::coef_t      calc_a2;
    dsp_pkg::coef_t      bank_b0;
    dsp_pkg::coef_t      bank_b1;
    dsp_pkg::coef_t      bank_b2;
    dsp_pkg::coef_t      bank_a1;
    dsp_pkg::coef_t      bank_a2;

    // ------------------------------------------------
    // Controller FSM
    // ------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            dsp_pkg::ST_IDLE: begin
                if (sample_in_rdy) next_state = dsp_pkg::ST_CALC_SAMPLE;
            end
            // Coefficients only move between samples
            dsp_pkg::ST_CALC_SAMPLE: begin
                if (sample_out_rdy) begin
                    next_state = params_changed ? dsp_pkg::ST_CALC_COEFS
                                                : dsp_pkg::ST_DONE;
                end
            end
            dsp_pkg::ST_CALC_COEFS: begin
                if (calc_done) next_state = dsp_pkg::ST_DONE;
            end
            default: next_state = dsp_pkg::ST_IDLE;
        endcase
    end

    // Strobes outside idle are dropped
    assign iir_start = sample_in_rdy && (state == dsp_pkg::ST_IDLE);

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state   <= dsp_pkg::ST_IDLE;
            do_calc <= 1'b0;
        end else begin
            state   <= next_state;
            // High on the first cycle in ST_CALC_COEFS, also clears the flag
            do_calc <= (state == dsp_pkg::ST_CALC_SAMPLE) && sample_out_rdy &&
                       params_changed;
        end
    end

    // Coefficient bank, zero until the first calculation
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            bank_b0 <= '0;
            bank_b1 <= '0;
            bank_b2 <= '0;
            bank_a1 <= '0;
            bank_a2 <= '0;
        end else if (calc_done) begin
            bank_b0 <= calc_b0;
            bank_b1 <= calc_b1;
            bank_b2 <= calc_b2;
            bank_a1 <= calc_a1;
            bank_a2 <= calc_a2;
        end
    end

    // ------------------------------------------------
    // Stage chain
    // ------------------------------------------------
    midi_cc_decoder u_decoder (
        .reset          (reset),
        .clk            (clk),
        .midi_rdy       (midi_rdy),
        .midi_cmd       (midi_cmd),
        .midi_ch        (midi_ch),
        .midi_data0     (midi_data0),
        .midi_data1     (midi_data1),
        .clear_changed  (do_calc),
        .omega0         (omega0),
        .inv_2q         (inv_2q),
        .params_changed (params_changed)
    );

    lpf_coefs_calc u_coefs (
        .reset     (reset),
        .clk       (clk),
        .do_calc   (do_calc),
        .omega0    (omega0),
        .inv_2q    (inv_2q),
        .b0        (calc_b0),
        .b1        (calc_b1),
        .b2        (calc_b2),
        .a1        (calc_a1),
        .a2        (calc_a2),
        .calc_done (calc_done)
    );

    // Biquad result goes straight out
    lpf_iir_biquad u_biquad (
        .reset      (reset),
        .clk        (clk),
        .start      (iir_start),
        .sample_in  (sample_in),
        .b0         (bank_b0),
        .b1         (bank_b1),
        .b2         (bank_b2),
        .a1         (bank_a1),
        .a2         (bank_a2),
        .done       (sample_out_rdy),
        .sample_out (sample_out),
        .overflow   (err_overflow)
    );

endmodule

// ==== tests/lpf_ref_model.svh ====
// --------------------------------------------------
// Integer reference model of the voice filter
// Parameter mapping, coefficient rule, DF-I biquad
// and the stimulus LFSR
// --------------------------------------------------
`ifndef LPF_REF_MODEL_SVH
`define LPF_REF_MODEL_SVH

// Model state, mirrors decoder, bank and history
longint ref_omega0;
longint ref_inv_2q;
bit     ref_changed;
longint ref_b0;
longint ref_b1;
longint ref_b2;
longint ref_a1;
longint ref_a2;
longint ref_x1;
longint ref_x2;
longint ref_y1;
longint ref_y2;

// 16-bit Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
endfunction

// Keep the low coefficient bits, sign extended
function automatic longint wrap_coef(input longint v);
    logic signed [`LPF_COEF_W-1:0] t;
    t = v[`LPF_COEF_W-1:0];
    return t;
endfunction

task automatic ref_reset();
    ref_omega0  = longint'(`LPF_OMEGA0_RST);
    ref_inv_2q  = longint'(`LPF_INV_2Q_RST);
    // Changed at reset, bank empty
    ref_changed = 1'b1;
    ref_b0      = 0;
    ref_b1      = 0;
    ref_b2      = 0;
    ref_a1      = 0;
    ref_a2      = 0;
    ref_x1      = 0;
    ref_x2      = 0;
    ref_y1      = 0;
    ref_y2      = 0;
endtask

// Multiply-only rule, products truncated by the Q shift
task automatic ref_coefs();
    longint w2;
    longint wd;
    w2     = (ref_omega0 * ref_omega0) >>> `LPF_FRAC;
    wd     = ((ref_omega0 * ref_inv_2q) >>> `LPF_FRAC) * 2;
    ref_b0 = wrap_coef(w2 >>> 2);
    ref_b1 = wrap_coef(w2 >>> 1);
    ref_b2 = wrap_coef(w2 >>> 2);
    ref_a1 = wrap_coef((longint'(2) <<< `LPF_FRAC) - w2 - wd);
    ref_a2 = wrap_coef((longint'(1) <<< `LPF_FRAC) - wd);
endtask

// Command 3 is Control Change
task automatic ref_midi(input logic [2:0] cmd, input logic [3:0] ch,
                        input logic [6:0] d0, input logic [6:0] d1);
    if (cmd == 3'd3 && ch == `LPF_MIDI_CH) begin
        if (d0 == `LPF_CC_OMEGA0) begin
            ref_omega0  = longint'({3'b000, d1, 8'hff});
            ref_changed = 1'b1;
        end
        if (d0 == `LPF_CC_INV_2Q) begin
            ref_inv_2q  = longint'({2'b00, d1, 9'h1ff});
            ref_changed = 1'b1;
        end
    end
endtask

// One sample through the recursion, then the coefficient pass
task automatic ref_sample(input longint x, output longint y, output bit ovf);
    longint acc;
    longint smax;
    longint smin;
    smax = (longint'(1) <<< (`LPF_SAMPLE_W - 1)) - 1;
    smin = -(longint'(1) <<< (`LPF_SAMPLE_W - 1));
    acc  = ref_b0 * x + ref_b1 * ref_x1 + ref_b2 * ref_x2 +
           ref_a1 * ref_y1 - ref_a2 * ref_y2;
    y    = acc >>> `LPF_FRAC;
    ovf  = 1'b0;
    if (y > smax) begin
        y   = smax;
        ovf = 1'b1;
    end else if (y < smin) begin
        y   = smin;
        ovf = 1'b1;
    end
    // Clipped value feeds back
    ref_x2 = ref_x1;
    ref_x1 = x;
    ref_y2 = ref_y1;
    ref_y1 = y;
    if (ref_changed) begin
        ref_coefs();
        ref_changed = 1'b0;
    end
endtask

`endif

// ==== tests/tb_lpf_voice_filter.sv ====
// --------------------------------------------------
// Testbench for the MIDI-controlled voice filter
// Table-driven CC events and samples, checked
// against the integer reference model
// --------------------------------------------------
`timescale 1ns/1ps
`include "lpf_defines.svh"

module tb_lpf_voice_filter;

    localparam logic [1:0] KIND_MIDI   = 2'd0;
    localparam logic [1:0] KIND_SAMPLE = 2'd1;
    localparam logic [1:0] KIND_RANDOM = 2'd2;
    localparam logic [1:0] KIND_DROP   = 2'd3;
    localparam int         OUT_TIMEOUT = 20;
    localparam int         IDLE_GAP    = 12;
    localparam int         CC_GAP      = 4;

    // One stimulus row
    typedef struct packed {
        logic [1:0]  kind;
        logic [2:0]  cmd;
        logic [3:0]  ch;
        logic [6:0]  d0;
        logic [6:0]  d1;
        logic [17:0] smp;
    } entry_t;

    // Port reset is the clock, clk the async reset
    logic                 reset;
    logic                 clk;
    logic                 midi_rdy;
    midi_pkg::midi_cmd_t  midi_cmd;
    midi_pkg::midi_ch_t   midi_ch;
    midi_pkg::midi_data_t midi_data0;
    midi_pkg::midi_data_t midi_data1;
    logic                 sample_in_rdy;
    dsp_pkg::sample_t     sample_in;
    logic                 sample_out_rdy;
    dsp_pkg::sample_t     sample_out;
    logic                 err_overflow;

    entry_t      table_q[$];
    logic [15:0] lfsr_state;
    int          error_count;
    int          pass_count;
    int          fail_count;

    `include "lpf_ref_model.svh"

    lpf_voice_filter UUT (
        .reset          (reset),
        .clk            (clk),
        .midi_rdy       (midi_rdy),
        .midi_cmd       (midi_cmd),
        .midi_ch        (midi_ch),
        .midi_data0     (midi_data0),
        .midi_data1     (midi_data1),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in      (sample_in),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out),
        .err_overflow   (err_overflow)
    );

    // 20 ns clock
    initial begin
        reset = 1'b0;
        forever #10 reset = ~reset;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    // Inputs move 2 ns after the edge, outputs read there too
    task automatic next_cycle();
        @(posedge reset);
        #2;
    endtask

    task automatic add_midi(input logic [2:0] cmd, input logic [3:0] ch,
                            input logic [6:0] d0, input logic [6:0] d1);
        entry_t e;
        e      = '0;
        e.kind = KIND_MIDI;
        e.cmd  = cmd;
        e.ch   = ch;
        e.d0   = d0;
        e.d1   = d1;
        table_q.push_back(e);
    endtask

    task automatic add_sample(input logic [1:0] kind, input logic [17:0] smp);
        entry_t e;
        e      = '0;
        e.kind = kind;
        e.smp  = smp;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        // Zero bank first, then defaults
        add_sample(KIND_SAMPLE, 18'h08000);
        add_sample(KIND_SAMPLE, 18'h08000);
        add_sample(KIND_SAMPLE, 18'h10000);
        // Cutoff then damping, first sample after each still old
        add_midi(3'd3, 4'd0, 7'd21, 7'h40);
        add_sample(KIND_SAMPLE, 18'h0c000);
        add_sample(KIND_SAMPLE, 18'h0c000);
        add_midi(3'd3, 4'd0, 7'd22, 7'h10);
        add_sample(KIND_SAMPLE, 18'h3f000);
        add_sample(KIND_SAMPLE, 18'h3f000);
        // Wrong channel, note on, unused CC number
        add_midi(3'd3, 4'd5, 7'd21, 7'h7f);
        add_midi(3'd1, 4'd0, 7'd21, 7'h05);
        add_midi(3'd3, 4'd0, 7'd30, 7'h11);
        add_sample(KIND_SAMPLE, 18'h04000);
        add_sample(KIND_SAMPLE, 18'h04000);
        for (int i = 0; i < 8; i++) add_sample(KIND_RANDOM, '0);
        // Wide cutoff, light damping, full-scale steps
        add_midi(3'd3, 4'd0, 7'd21, 7'h7f);
        add_midi(3'd3, 4'd0, 7'd22, 7'h00);
        for (int i = 0; i < 10; i++) add_sample(KIND_SAMPLE, 18'h1ffff);
        for (int i = 0; i < 6; i++) add_sample(KIND_SAMPLE, 18'h20000);
        add_sample(KIND_DROP, 18'h02000);
        add_sample(KIND_SAMPLE, 18'h01000);
    endtask

    // One LFSR step per bit
    task automatic draw_random(output dsp_pkg::sample_t v);
        for (int b = 0; b < `LPF_SAMPLE_W; b++) begin
            v[b]       = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            KIND_MIDI:   return "midi";
            KIND_SAMPLE: return "sample";
            KIND_RANDOM: return "random";
            default:     return "drop";
        endcase
    endfunction

    // Nothing may come out between samples
    task automatic idle_cycles(input int idx, input int n);
        repeat (n) begin
            next_cycle();
            if (sample_out_rdy === 1'b1 || err_overflow === 1'b1) begin
                $display("Entry %0d: unexpected output pulse while no sample was pending", idx);
                error_count++;
            end
        end
    endtask

    task automatic apply_midi(input int idx, input entry_t e);
        midi_cmd   = midi_pkg::midi_cmd_t'(e.cmd);
        midi_ch    = e.ch;
        midi_data0 = e.d0;
        midi_data1 = e.d1;
        midi_rdy   = 1'b1;
        ref_midi(e.cmd, e.ch, e.d0, e.d1);
        next_cycle();
        midi_rdy   = 1'b0;
        idle_cycles(idx, CC_GAP);
    endtask

    task automatic run_sample(input int idx, input dsp_pkg::sample_t value, input bit drop);
        longint exp_y;
        bit     exp_ovf;
        int     waited;
        ref_sample(longint'(value), exp_y, exp_ovf);
        sample_in     = value;
        sample_in_rdy = 1'b1;
        next_cycle();
        sample_in_rdy = 1'b0;
        waited        = 1;
        while (sample_out_rdy !== 1'b1 && waited < OUT_TIMEOUT) begin
            // Extra strobe while the controller is busy
            sample_in_rdy = drop && (waited == 3);
            if (sample_in_rdy) begin
                sample_in = ~value;
            end
            next_cycle();
            waited++;
        end
        sample_in_rdy = 1'b0;
        if (sample_out_rdy !== 1'b1) begin
            $display("Entry %0d: sample_out_rdy did not arrive within %0d cycles",
                     idx, OUT_TIMEOUT);
            error_count++;
        end else begin
            if (sample_out !== dsp_pkg::sample_t'(exp_y)) begin
                $display("[ERROR] entry %0d sample_out expected %05h got %05h",
                         idx, dsp_pkg::sample_t'(exp_y), sample_out);
                error_count++;
            end
            if (err_overflow !== exp_ovf) begin
                $display("[ERROR] entry %0d err_overflow expected %0h got %0h",
                         idx, exp_ovf, err_overflow);
                error_count++;
            end
        end
        // Room for the coefficient pass
        idle_cycles(idx, IDLE_GAP);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        entry_t           e;
        int               errs_before;
        dsp_pkg::sample_t value;
        lfsr_state    = 16'd55232;
        error_count   = 0;
        pass_count    = 0;
        fail_count    = 0;
        clk           = 1'b1;
        midi_rdy      = 1'b0;
        midi_cmd      = midi_pkg::MIDI_NOTE_OFF;
        midi_ch       = '0;
        midi_data0    = '0;
        midi_data1    = '0;
        sample_in_rdy = 1'b0;
        sample_in     = '0;
        build_table();
        ref_reset();
        repeat (2) @(posedge reset);
        #2;
        clk = 1'b0;
        next_cycle();
        for (int i = 0; i < table_q.size(); i++) begin
            errs_before = error_count;
            e           = table_q[i];
            case (e.kind)
                KIND_MIDI: apply_midi(i, e);
                KIND_RANDOM: begin
                    draw_random(value);
                    run_sample(i, value, 1'b0);
                end
                default: run_sample(i, e.smp, e.kind == KIND_DROP);
            endcase
            if (error_count == errs_before) begin
                pass_count++;
                $display("entry %0d %s: pass", i, kind_name(e.kind));
            end else begin
                fail_count++;
                $display("entry %0d %s: FAIL", i, kind_name(e.kind));
            end
        end
        $display("Summary: %0d entries passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog, about 40 cycles per table row
    initial begin
        int limit;
        #1;
        limit = table_q.size() * 40 + 200;
        repeat (limit) @(posedge reset);
        $display("Watchdog expired after %0d cycles, the run did not finish", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+logic
+incdir+tests
logic/midi_pkg.sv
logic/dsp_pkg.sv
logic/midi_cc_decoder.sv
logic/lpf_coefs_calc.sv
logic/lpf_iir_biquad.sv
logic/lpf_voice_filter.sv
tests/tb_lpf_voice_filter.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the voice filter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    -f filelist.f \
    --top-module tb_lpf_voice_filter \
    -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
